// File: source/adq_regs_cfg.svh
`ifndef ADQ_REGS_CFG_SVH
`define ADQ_REGS_CFG_SVH

// Bus widths
`define REG_ADDR_W 15
`define REG_DATA_W 16

// Register counts
`define VER_WORD_N 4
`define USER_IN_N  8
`define USER_OUT_N 8
`define ADC_CHAN_N 2

// Narrow system fields
`define AFE_CTRL_W      4
`define DECIM_W         9
`define LED_W           3
`define POWERDOWN_W     2
`define DATA_FORMAT_W   2
`define IDELAY_W        3
`define IDELAY_LOAD_BIT 2

//////////////////////////////
// Register map
`define ADDR_VER         15'h0000
`define ADDR_USER_STATUS 15'h0020
`define ADDR_USER_CTRL   15'h0030
`define ADDR_SAMPLE_SKIP 15'h2AA0
`define ADDR_IDELAY      15'h2AA1
`define ADDR_AFE_CTRL    15'h2AA2
`define ADDR_DECIM       15'h2AA3
`define ADDR_LED         15'h2AAA
`define ADDR_POWERDOWN   15'h2AAB
`define ADDR_DATA_FORMAT 15'h2AAC
// Per channel, plus the channel index
`define ADDR_GAIN        15'h2AB0
`define ADDR_OFFSET      15'h2AC0
`define ADDR_MAX_CODE    15'h2AD0
`define ADDR_MIN_CODE    15'h2AD2

//////////////////////////////
// Version fields
`define VER_PRJ   6'h11
`define VER_FCN   4'h2
`define VER_MAJOR 6'h03
`define VER_MINOR 8'h07
`define VER_REL   8'h01
`define VER_VLDTR 8'hA5

// Calibration defaults
`define CAL_GAIN_RST   16'sd1024
`define CAL_OFFSET_RST 16'sd0
`define CAL_MAX_RST    16'sd8191
`define CAL_MIN_RST    (-16'sd8192)

`endif

// File: source/adq_regs_pkg.sv
`default_nettype none
`include "adq_regs_cfg.svh"

package adq_regs_pkg;

    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`REG_DATA_W-1:0] reg_data_t;
    typedef logic signed [`REG_DATA_W-1:0] cal_word_t;
    typedef logic [`USER_OUT_N-1:0] user_strobe_t;
    // Bit 2 load request, bits 1:0 tap step
    typedef logic [`IDELAY_W-1:0] idelay_t;

    // Bank request, valid for one cycle in ACCESS
    typedef struct packed {
        logic      wr;
        logic      rd;
        reg_addr_t addr;
        reg_data_t wdata;
    } reg_req_t;

    typedef struct packed {
        reg_data_t rdata;
        logic      hit;
        logic      err;
    } reg_rsp_t;

    typedef struct packed {
        cal_word_t gain;
        cal_word_t offset;
        cal_word_t max_code;
        cal_word_t min_code;
    } cal_chan_t;

    typedef struct packed {
        reg_data_t                 sample_skip;
        logic [`AFE_CTRL_W-1:0]    afe_ctrl;
        logic [`DECIM_W-1:0]       decim;
        logic [`LED_W-1:0]         led;
        logic [`POWERDOWN_W-1:0]   powerdown;
        logic [`DATA_FORMAT_W-1:0] data_format;
    } adc_sys_t;

    typedef enum logic [1:0] {
        IDLE,
        ACCESS,
        DONE
    } port_state_t;

endpackage

`default_nettype wire

// File: source/apb_reg_port.sv
`timescale 1ns/1ps
`default_nettype none

module apb_reg_port (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire adq_regs_pkg::reg_addr_t paddr_i,
    input  wire                          psel_i,
    input  wire                          penable_i,
    input  wire                          pwrite_i,
    input  wire adq_regs_pkg::reg_data_t pwdata_i,
    output adq_regs_pkg::reg_data_t      prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    output adq_regs_pkg::reg_req_t       req_o,
    input  wire adq_regs_pkg::reg_rsp_t  board_rsp_i,
    input  wire adq_regs_pkg::reg_rsp_t  cal_rsp_i
);
    import adq_regs_pkg::*;

    port_state_t state_q;
    reg_req_t    req_q;
    logic        err_q;
    logic        setup;
    logic        in_access;
    logic        in_done;

    assign setup     = (state_q == IDLE) && psel_i && !penable_i;
    assign in_access = (state_q == ACCESS);
    assign in_done   = (state_q == DONE);

    // Capture of the setup phase
    always_ff @(posedge clk_i) begin
        if (setup) begin
            req_q.wr    <= pwrite_i;
            req_q.rd    <= !pwrite_i;
            req_q.addr  <= paddr_i;
            req_q.wdata <= pwdata_i;
        end
    end

    //////////////////////////////
    // Transfer FSM
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (setup) begin
                        state_q <= ACCESS;
                    end
                end
                ACCESS: begin
                    // Nobody claimed the address, or a read-only write
                    err_q   <= !(board_rsp_i.hit || cal_rsp_i.hit)
                               || board_rsp_i.err || cal_rsp_i.err;
                    state_q <= DONE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // Request flags only live in ACCESS
    always_comb begin
        req_o    = req_q;
        req_o.wr = req_q.wr && in_access;
        req_o.rd = req_q.rd && in_access;
    end

    assign pready_o  = in_done;
    assign pslverr_o = in_done && err_q;
    assign prdata_o  = in_done ? (board_rsp_i.rdata | cal_rsp_i.rdata) : '0;

endmodule

`default_nettype wire

// File: source/board_reg_bank.sv
`timescale 1ns/1ps
`default_nettype none
`include "adq_regs_cfg.svh"

module board_reg_bank (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire adq_regs_pkg::reg_req_t  req_i,
    output adq_regs_pkg::reg_rsp_t       rsp_o,
    input  wire adq_regs_pkg::reg_data_t user_status_i [`USER_IN_N],
    output adq_regs_pkg::reg_data_t      user_ctrl_o [`USER_OUT_N],
    output adq_regs_pkg::user_strobe_t   user_strobe_o
);
    import adq_regs_pkg::*;

    localparam int VER_IDX_W = $clog2(`VER_WORD_N);
    localparam int IN_IDX_W  = $clog2(`USER_IN_N);
    localparam int OUT_IDX_W = $clog2(`USER_OUT_N);

    reg_data_t    ver_word [`VER_WORD_N];
    reg_data_t    status_q [`USER_IN_N];
    reg_data_t    ctrl_q [`USER_OUT_N];
    user_strobe_t strobe_q;
    reg_data_t    rdata_q;
    reg_data_t    rd_mux;
    reg_addr_t    ver_off;
    reg_addr_t    status_off;
    reg_addr_t    ctrl_off;
    logic         in_ver;
    logic         in_status;
    logic         in_ctrl;
    logic         valid;

    // Version words, fixed at build time
    assign ver_word[0] = {`VER_MINOR, `VER_REL};
    assign ver_word[1] = {`VER_PRJ, `VER_FCN, `VER_MAJOR};
    assign ver_word[2] = '0;
    assign ver_word[3] = {`VER_VLDTR, 8'h00};

    assign valid      = req_i.wr || req_i.rd;
    assign ver_off    = req_i.addr - `ADDR_VER;
    assign status_off = req_i.addr - `ADDR_USER_STATUS;
    assign ctrl_off   = req_i.addr - `ADDR_USER_CTRL;
    assign in_ver     = ver_off < `VER_WORD_N;
    assign in_status  = status_off < `USER_IN_N;
    assign in_ctrl    = ctrl_off < `USER_OUT_N;

    always_comb begin
        rd_mux = '0;
        if (in_ver) begin
            rd_mux = ver_word[ver_off[VER_IDX_W-1:0]];
        end else if (in_status) begin
            rd_mux = status_q[status_off[IN_IDX_W-1:0]];
        end else if (in_ctrl) begin
            rd_mux = ctrl_q[ctrl_off[OUT_IDX_W-1:0]];
        end
    end

    // Version and status are read-only
    assign rsp_o = '{rdata: rdata_q,
                     hit:   valid && (in_ver || in_status || in_ctrl),
                     err:   req_i.wr && (in_ver || in_status)};

    always_ff @(posedge clk_i) begin
        status_q <= user_status_i;
        if (valid) begin
            rdata_q <= rd_mux;
        end
    end

    //////////////////////////////
    // User control registers
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ctrl_q   <= '{default: '0};
            strobe_q <= '0;
        end else begin
            strobe_q <= '0;
            if (req_i.wr && in_ctrl) begin
                ctrl_q[ctrl_off[OUT_IDX_W-1:0]]   <= req_i.wdata;
                strobe_q[ctrl_off[OUT_IDX_W-1:0]] <= 1'b1;
            end
        end
    end

    // Strobe stays aligned with the new value
    always_ff @(posedge clk_i) begin
        user_ctrl_o   <= ctrl_q;
        user_strobe_o <= strobe_q;
    end

endmodule

`default_nettype wire

// File: source/adc_cal_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "adq_regs_cfg.svh"

module adc_cal_regs (
    input  wire                         clk_i,
    input  wire                         rst_i,
    input  wire adq_regs_pkg::reg_req_t req_i,
    output adq_regs_pkg::reg_rsp_t      rsp_o,
    output adq_regs_pkg::adc_sys_t      sys_o,
    output adq_regs_pkg::cal_chan_t     cal_o [`ADC_CHAN_N],
    output adq_regs_pkg::idelay_t       idelay_set_o
);
    import adq_regs_pkg::*;

    adc_sys_t  sys_q;
    cal_chan_t cal_q [`ADC_CHAN_N];
    idelay_t   idelay_q;
    reg_data_t rd_mux;
    reg_data_t rdata_q;
    logic      addr_hit;
    logic      valid;

    assign valid = req_i.wr || req_i.rd;

    //////////////////////////////
    // Readback, narrow fields zero-extended
    always_comb begin
        rd_mux   = '0;
        addr_hit = 1'b1;
        case (req_i.addr)
            `ADDR_SAMPLE_SKIP:
                rd_mux = sys_q.sample_skip;
            `ADDR_IDELAY:
                rd_mux = reg_data_t'(idelay_q);
            `ADDR_AFE_CTRL:
                rd_mux = reg_data_t'(sys_q.afe_ctrl);
            `ADDR_DECIM:
                rd_mux = reg_data_t'(sys_q.decim);
            `ADDR_LED:
                rd_mux = reg_data_t'(sys_q.led);
            `ADDR_POWERDOWN:
                rd_mux = reg_data_t'(sys_q.powerdown);
            `ADDR_DATA_FORMAT:
                rd_mux = reg_data_t'(sys_q.data_format);
            default:
                addr_hit = 1'b0;
        endcase
        for (int ch = 0; ch < `ADC_CHAN_N; ch++) begin
            if (req_i.addr == reg_addr_t'(`ADDR_GAIN + ch)) begin
                rd_mux   = reg_data_t'(cal_q[ch].gain);
                addr_hit = 1'b1;
            end
            if (req_i.addr == reg_addr_t'(`ADDR_OFFSET + ch)) begin
                rd_mux   = reg_data_t'(cal_q[ch].offset);
                addr_hit = 1'b1;
            end
            if (req_i.addr == reg_addr_t'(`ADDR_MAX_CODE + ch)) begin
                rd_mux   = reg_data_t'(cal_q[ch].max_code);
                addr_hit = 1'b1;
            end
            if (req_i.addr == reg_addr_t'(`ADDR_MIN_CODE + ch)) begin
                rd_mux   = reg_data_t'(cal_q[ch].min_code);
                addr_hit = 1'b1;
            end
        end
    end

    // Everything here is writable
    assign rsp_o = '{rdata: rdata_q, hit: valid && addr_hit, err: 1'b0};

    always_ff @(posedge clk_i) begin
        if (valid) begin
            rdata_q <= rd_mux;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            sys_q    <= '0;
            idelay_q <= '0;
            for (int ch = 0; ch < `ADC_CHAN_N; ch++) begin
                cal_q[ch].gain     <= `CAL_GAIN_RST;
                cal_q[ch].offset   <= `CAL_OFFSET_RST;
                cal_q[ch].max_code <= `CAL_MAX_RST;
                cal_q[ch].min_code <= `CAL_MIN_RST;
            end
        end else if (req_i.wr) begin
            case (req_i.addr)
                `ADDR_SAMPLE_SKIP:
                    sys_q.sample_skip <= req_i.wdata;
                `ADDR_IDELAY:
                    idelay_q <= req_i.wdata[`IDELAY_W-1:0];
                `ADDR_AFE_CTRL:
                    sys_q.afe_ctrl <= req_i.wdata[`AFE_CTRL_W-1:0];
                `ADDR_DECIM:
                    sys_q.decim <= req_i.wdata[`DECIM_W-1:0];
                `ADDR_LED:
                    sys_q.led <= req_i.wdata[`LED_W-1:0];
                `ADDR_POWERDOWN:
                    sys_q.powerdown <= req_i.wdata[`POWERDOWN_W-1:0];
                `ADDR_DATA_FORMAT:
                    sys_q.data_format <= req_i.wdata[`DATA_FORMAT_W-1:0];
                default: begin
                end
            endcase
            for (int ch = 0; ch < `ADC_CHAN_N; ch++) begin
                if (req_i.addr == reg_addr_t'(`ADDR_GAIN + ch)) begin
                    cal_q[ch].gain <= req_i.wdata;
                end
                if (req_i.addr == reg_addr_t'(`ADDR_OFFSET + ch)) begin
                    cal_q[ch].offset <= req_i.wdata;
                end
                if (req_i.addr == reg_addr_t'(`ADDR_MAX_CODE + ch)) begin
                    cal_q[ch].max_code <= req_i.wdata;
                end
                if (req_i.addr == reg_addr_t'(`ADDR_MIN_CODE + ch)) begin
                    cal_q[ch].min_code <= req_i.wdata;
                end
            end
        end
    end

    // Pipelined copies toward the datapath
    always_ff @(posedge clk_i) begin
        sys_o <= sys_q;
        cal_o <= cal_q;
    end

    assign idelay_set_o = idelay_q;

endmodule

`default_nettype wire

// File: source/idelay_strobe.sv
`timescale 1ns/1ps
`default_nettype none
`include "adq_regs_cfg.svh"

module idelay_strobe (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire adq_regs_pkg::idelay_t idelay_set_i,
    output adq_regs_pkg::idelay_t      idelay_o
);
    import adq_regs_pkg::*;

    idelay_t stage1_q;
    idelay_t stage2_q;
    logic    load_d_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            stage1_q <= '0;
            stage2_q <= '0;
            load_d_q <= 1'b0;
            idelay_o <= '0;
        end else begin
            stage1_q <= idelay_set_i;
            stage2_q <= stage1_q;
            load_d_q <= stage2_q[`IDELAY_LOAD_BIT];
            // Load pulse on rising edge only, tap step kept
            if (stage2_q[`IDELAY_LOAD_BIT] && !load_d_q) begin
                idelay_o <= stage2_q;
            end else begin
                idelay_o[`IDELAY_LOAD_BIT] <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/adq_regs_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "adq_regs_cfg.svh"

module adq_regs_top (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire adq_regs_pkg::reg_addr_t paddr_i,
    input  wire                          psel_i,
    input  wire                          penable_i,
    input  wire                          pwrite_i,
    input  wire adq_regs_pkg::reg_data_t pwdata_i,
    output adq_regs_pkg::reg_data_t      prdata_o,
    output logic                         pready_o,
    output logic                         pslverr_o,
    input  wire adq_regs_pkg::reg_data_t user_status_i [`USER_IN_N],
    output adq_regs_pkg::reg_data_t      user_ctrl_o [`USER_OUT_N],
    output adq_regs_pkg::user_strobe_t   user_strobe_o,
    output adq_regs_pkg::adc_sys_t       sys_o,
    output adq_regs_pkg::cal_chan_t      cal_o [`ADC_CHAN_N],
    output adq_regs_pkg::idelay_t        idelay_o
);
    import adq_regs_pkg::*;

    wire reg_req_t req;
    wire reg_rsp_t board_rsp;
    wire reg_rsp_t cal_rsp;
    wire idelay_t  idelay_set;

    apb_reg_port u_port (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .paddr_i     (paddr_i),
        .psel_i      (psel_i),
        .penable_i   (penable_i),
        .pwrite_i    (pwrite_i),
        .pwdata_i    (pwdata_i),
        .prdata_o    (prdata_o),
        .pready_o    (pready_o),
        .pslverr_o   (pslverr_o),
        .req_o       (req),
        .board_rsp_i (board_rsp),
        .cal_rsp_i   (cal_rsp)
    );

    //////////////////////////////
    // Register banks
    board_reg_bank u_board (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .req_i         (req),
        .rsp_o         (board_rsp),
        .user_status_i (user_status_i),
        .user_ctrl_o   (user_ctrl_o),
        .user_strobe_o (user_strobe_o)
    );

    adc_cal_regs u_cal (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .req_i        (req),
        .rsp_o        (cal_rsp),
        .sys_o        (sys_o),
        .cal_o        (cal_o),
        .idelay_set_o (idelay_set)
    );

    // Delay line load pulse
    idelay_strobe u_idelay (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .idelay_set_i (idelay_set),
        .idelay_o     (idelay_o)
    );

endmodule

`default_nettype wire

// File: tests/adq_regs_model.svh
`ifndef ADQ_REGS_MODEL_SVH
`define ADQ_REGS_MODEL_SVH

//////////////////////////////
// Shadow register map
reg_data_t m_ctrl [`USER_OUT_N];
reg_data_t m_status [`USER_IN_N];
adc_sys_t  m_sys;
cal_chan_t m_cal [`ADC_CHAN_N];
idelay_t   m_idelay_set;
idelay_t   m_idelay_out;
reg_addr_t rw_addrs [$];

function automatic void reset_model();
    m_ctrl       = '{default: '0};
    m_status     = '{default: '0};
    m_sys        = '0;
    m_idelay_set = '0;
    m_idelay_out = '0;
    for (int ch = 0; ch < `ADC_CHAN_N; ch++) begin
        m_cal[ch].gain     = `CAL_GAIN_RST;
        m_cal[ch].offset   = `CAL_OFFSET_RST;
        m_cal[ch].max_code = `CAL_MAX_RST;
        m_cal[ch].min_code = `CAL_MIN_RST;
    end
endfunction

// Writable registers, input delay left out
function automatic void build_addr_list();
    for (int i = 0; i < `USER_OUT_N; i++) begin
        rw_addrs.push_back(reg_addr_t'(`ADDR_USER_CTRL + i));
    end
    rw_addrs.push_back(`ADDR_SAMPLE_SKIP);
    rw_addrs.push_back(`ADDR_AFE_CTRL);
    rw_addrs.push_back(`ADDR_DECIM);
    rw_addrs.push_back(`ADDR_LED);
    rw_addrs.push_back(`ADDR_POWERDOWN);
    rw_addrs.push_back(`ADDR_DATA_FORMAT);
    for (int ch = 0; ch < `ADC_CHAN_N; ch++) begin
        rw_addrs.push_back(reg_addr_t'(`ADDR_GAIN + ch));
        rw_addrs.push_back(reg_addr_t'(`ADDR_OFFSET + ch));
        rw_addrs.push_back(reg_addr_t'(`ADDR_MAX_CODE + ch));
        rw_addrs.push_back(reg_addr_t'(`ADDR_MIN_CODE + ch));
    end
endfunction

function automatic bit in_range(reg_addr_t addr, reg_addr_t base, int n);
    return int'(addr) >= int'(base) && int'(addr) < int'(base) + n;
endfunction

function automatic bit is_mapped(reg_addr_t addr);
    return in_range(addr, `ADDR_VER, `VER_WORD_N)
        || in_range(addr, `ADDR_USER_STATUS, `USER_IN_N)
        || in_range(addr, `ADDR_USER_CTRL, `USER_OUT_N)
        || in_range(addr, `ADDR_SAMPLE_SKIP, 4)
        || in_range(addr, `ADDR_LED, 3)
        || in_range(addr, `ADDR_GAIN, `ADC_CHAN_N)
        || in_range(addr, `ADDR_OFFSET, `ADC_CHAN_N)
        || in_range(addr, `ADDR_MAX_CODE, `ADC_CHAN_N)
        || in_range(addr, `ADDR_MIN_CODE, `ADC_CHAN_N);
endfunction

function automatic reg_data_t version_word(int idx);
    case (idx)
        0: return {`VER_MINOR, `VER_REL};
        1: return {`VER_PRJ, `VER_FCN, `VER_MAJOR};
        3: return {`VER_VLDTR, 8'h00};
        default: return '0;
    endcase
endfunction

function automatic reg_data_t model_read(reg_addr_t addr);
    reg_data_t rd;
    rd = '0;
    if (in_range(addr, `ADDR_VER, `VER_WORD_N)) begin
        rd = version_word(int'(addr) - int'(`ADDR_VER));
    end else if (in_range(addr, `ADDR_USER_STATUS, `USER_IN_N)) begin
        rd = m_status[int'(addr) - int'(`ADDR_USER_STATUS)];
    end else if (in_range(addr, `ADDR_USER_CTRL, `USER_OUT_N)) begin
        rd = m_ctrl[int'(addr) - int'(`ADDR_USER_CTRL)];
    end
    // Narrow fields read back zero-extended
    case (addr)
        `ADDR_SAMPLE_SKIP: rd = m_sys.sample_skip;
        `ADDR_IDELAY:      rd = reg_data_t'(m_idelay_set);
        `ADDR_AFE_CTRL:    rd = reg_data_t'(m_sys.afe_ctrl);
        `ADDR_DECIM:       rd = reg_data_t'(m_sys.decim);
        `ADDR_LED:         rd = reg_data_t'(m_sys.led);
        `ADDR_POWERDOWN:   rd = reg_data_t'(m_sys.powerdown);
        `ADDR_DATA_FORMAT: rd = reg_data_t'(m_sys.data_format);
        default: begin
        end
    endcase
    for (int ch = 0; ch < `ADC_CHAN_N; ch++) begin
        if (addr == reg_addr_t'(`ADDR_GAIN + ch)) rd = reg_data_t'(m_cal[ch].gain);
        if (addr == reg_addr_t'(`ADDR_OFFSET + ch)) rd = reg_data_t'(m_cal[ch].offset);
        if (addr == reg_addr_t'(`ADDR_MAX_CODE + ch)) rd = reg_data_t'(m_cal[ch].max_code);
        if (addr == reg_addr_t'(`ADDR_MIN_CODE + ch)) rd = reg_data_t'(m_cal[ch].min_code);
    end
    return rd;
endfunction

function automatic void model_write(reg_addr_t addr, reg_data_t data);
    if (in_range(addr, `ADDR_USER_CTRL, `USER_OUT_N)) begin
        m_ctrl[int'(addr) - int'(`ADDR_USER_CTRL)] = data;
    end
    case (addr)
        `ADDR_SAMPLE_SKIP: m_sys.sample_skip = data;
        `ADDR_IDELAY:      m_idelay_set = data[`IDELAY_W-1:0];
        `ADDR_AFE_CTRL:    m_sys.afe_ctrl = data[`AFE_CTRL_W-1:0];
        `ADDR_DECIM:       m_sys.decim = data[`DECIM_W-1:0];
        `ADDR_LED:         m_sys.led = data[`LED_W-1:0];
        `ADDR_POWERDOWN:   m_sys.powerdown = data[`POWERDOWN_W-1:0];
        `ADDR_DATA_FORMAT: m_sys.data_format = data[`DATA_FORMAT_W-1:0];
        default: begin
        end
    endcase
    for (int ch = 0; ch < `ADC_CHAN_N; ch++) begin
        if (addr == reg_addr_t'(`ADDR_GAIN + ch)) m_cal[ch].gain = data;
        if (addr == reg_addr_t'(`ADDR_OFFSET + ch)) m_cal[ch].offset = data;
        if (addr == reg_addr_t'(`ADDR_MAX_CODE + ch)) m_cal[ch].max_code = data;
        if (addr == reg_addr_t'(`ADDR_MIN_CODE + ch)) m_cal[ch].min_code = data;
    end
endfunction

// One-hot strobe that a write to addr should raise
function automatic user_strobe_t model_strobe(reg_addr_t addr);
    user_strobe_t exp;
    exp = '0;
    if (in_range(addr, `ADDR_USER_CTRL, `USER_OUT_N)) begin
        exp[int'(addr) - int'(`ADDR_USER_CTRL)] = 1'b1;
    end
    return exp;
endfunction

//////////////////////////////
// Compare tasks
task automatic abort_run(string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped");
endtask

task automatic check_data(string name, reg_data_t exp, reg_data_t act);
    if (exp !== act) begin
        abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_flag(string name, logic exp, logic act);
    if (exp !== act) begin
        abort_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
    end
endtask

task automatic check_strobe(string name, user_strobe_t exp, user_strobe_t act);
    if (exp !== act) begin
        abort_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
    end
endtask

task automatic check_cal(string name, cal_chan_t exp, cal_chan_t act);
    if (exp !== act) begin
        abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_sys(string name, adc_sys_t exp, adc_sys_t act);
    if (exp !== act) begin
        abort_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
endtask

task automatic check_idelay(string name, idelay_t exp, idelay_t act);
    if (exp !== act) begin
        abort_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
    end
endtask

task automatic check_outputs(string name, user_strobe_t exp_strobe);
    for (int i = 0; i < `USER_OUT_N; i++) begin
        check_data($sformatf("%s ctrl[%0d]", name, i), m_ctrl[i], user_ctrl[i]);
    end
    check_strobe({name, " strobe"}, exp_strobe, user_strobe);
    check_sys({name, " sys"}, m_sys, sys);
    for (int ch = 0; ch < `ADC_CHAN_N; ch++) begin
        check_cal($sformatf("%s cal[%0d]", name, ch), m_cal[ch], cal[ch]);
    end
    check_idelay({name, " idelay"}, m_idelay_out, idelay);
endtask

//////////////////////////////
// APB master
task automatic apb_xfer(input logic wr, input reg_addr_t addr, input reg_data_t wdata,
                        output reg_data_t rdata, output logic err);
    int waits;
    waits = 0;
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    while (!pready) begin
        if (waits == 1) begin
            abort_run($sformatf("No pready within the second access cycle at %h", addr));
        end
        @(negedge clk);
        waits++;
    end
    rdata   = prdata;
    err     = pslverr;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic read_check(string name, reg_addr_t addr, reg_data_t exp, logic exp_err);
    reg_data_t rd;
    logic      err;
    apb_xfer(1'b0, addr, '0, rd, err);
    check_data($sformatf("%s @%h", name, addr), exp, rd);
    check_flag($sformatf("%s @%h pslverr", name, addr), exp_err, err);
endtask

task automatic write_check(string name, reg_addr_t addr, reg_data_t data, logic exp_err);
    reg_data_t rd;
    logic      err;
    apb_xfer(1'b1, addr, data, rd, err);
    check_flag($sformatf("%s @%h pslverr", name, addr), exp_err, err);
endtask

`endif

// File: tests/adq_regs_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "adq_regs_cfg.svh"

module adq_regs_tb;
    import adq_regs_pkg::*;

    localparam int RST_CYCLES  = 16;
    localparam int RAND_XFERS  = 400;
    localparam int XFER_N      = 520;
    localparam int XFER_CYCLES = 6;
    localparam int CYCLE_LIMIT = 4 * (RST_CYCLES + XFER_N * XFER_CYCLES);

    logic         clk;
    logic         rst;
    reg_addr_t    paddr;
    logic         psel;
    logic         penable;
    logic         pwrite;
    reg_data_t    pwdata;
    reg_data_t    prdata;
    logic         pready;
    logic         pslverr;
    reg_data_t    user_status [`USER_IN_N];
    reg_data_t    user_ctrl [`USER_OUT_N];
    user_strobe_t user_strobe;
    adc_sys_t     sys;
    cal_chan_t    cal [`ADC_CHAN_N];
    idelay_t      idelay;
    integer       seed;
    int           cycle_cnt = 0;

    `include "adq_regs_model.svh"

    adq_regs_top u_dut (
        .clk_i         (clk),
        .rst_i         (rst),
        .paddr_i       (paddr),
        .psel_i        (psel),
        .penable_i     (penable),
        .pwrite_i      (pwrite),
        .pwdata_i      (pwdata),
        .prdata_o      (prdata),
        .pready_o      (pready),
        .pslverr_o     (pslverr),
        .user_status_i (user_status),
        .user_ctrl_o   (user_ctrl),
        .user_strobe_o (user_strobe),
        .sys_o         (sys),
        .cal_o         (cal),
        .idelay_o      (idelay)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycle_cnt);
            $display("TESTS FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic sweep_readback(string name);
        for (int i = 0; i < `VER_WORD_N; i++) begin
            read_check(name, reg_addr_t'(`ADDR_VER + i), version_word(i), 1'b0);
        end
        read_check(name, `ADDR_IDELAY, model_read(`ADDR_IDELAY), 1'b0);
        foreach (rw_addrs[i]) begin
            read_check(name, rw_addrs[i], model_read(rw_addrs[i]), 1'b0);
        end
    endtask

    task automatic status_checks();
        logic [31:0] rnd;
        @(negedge clk);
        for (int i = 0; i < `USER_IN_N; i++) begin
            rnd            = $random(seed);
            user_status[i] = rnd[`REG_DATA_W-1:0];
            m_status[i]    = rnd[`REG_DATA_W-1:0];
        end
        for (int i = 0; i < `USER_IN_N; i++) begin
            read_check("status readback", reg_addr_t'(`ADDR_USER_STATUS + i), m_status[i], 1'b0);
        end
    endtask

    task automatic random_xfers();
        logic [31:0] rnd;
        reg_addr_t   addr;
        reg_data_t   data;
        logic        wr;
        for (int n = 0; n < RAND_XFERS; n++) begin
            rnd  = $random(seed);
            addr = rw_addrs[rnd % rw_addrs.size()];
            wr   = rnd[31];
            rnd  = $random(seed);
            data = rnd[`REG_DATA_W-1:0];
            if (wr) begin
                model_write(addr, data);
                write_check("random write", addr, data, 1'b0);
                @(negedge clk);
                check_outputs("outputs after write", model_strobe(addr));
                // Strobe lasts a single cycle
                @(negedge clk);
                check_strobe("strobe one cycle later", '0, user_strobe);
            end else begin
                read_check("random read", addr, model_read(addr), 1'b0);
                @(negedge clk);
                check_outputs("outputs after read", '0);
            end
        end
    endtask

    task automatic error_checks();
        logic [31:0] rnd;
        reg_addr_t   addr;
        for (int n = 0; n < 16; n++) begin
            rnd  = $random(seed);
            addr = rnd[`REG_ADDR_W-1:0];
            while (is_mapped(addr)) begin
                rnd  = $random(seed);
                addr = rnd[`REG_ADDR_W-1:0];
            end
            read_check("unmapped read", addr, '0, 1'b1);
        end
        for (int i = 0; i < `VER_WORD_N + `USER_IN_N; i++) begin
            if (i < `VER_WORD_N) begin
                addr = reg_addr_t'(`ADDR_VER + i);
            end else begin
                addr = reg_addr_t'(`ADDR_USER_STATUS + i - `VER_WORD_N);
            end
            rnd = $random(seed);
            write_check("read-only write", addr, rnd[`REG_DATA_W-1:0], 1'b1);
            read_check("read-only after write", addr, model_read(addr), 1'b0);
        end
        @(negedge clk);
        check_outputs("outputs after rejected writes", '0);
        sweep_readback("readback after rejected writes");
    endtask

    // Pulse lands three cycles after the write edge
    task automatic idelay_write(string name, idelay_t value);
        logic pulse;
        pulse = value[`IDELAY_LOAD_BIT] && !m_idelay_set[`IDELAY_LOAD_BIT];
        model_write(`ADDR_IDELAY, reg_data_t'(value));
        write_check(name, `ADDR_IDELAY, reg_data_t'(value), 1'b0);
        check_idelay(name, m_idelay_out, idelay);
        for (int k = 1; k <= 4; k++) begin
            @(negedge clk);
            if (pulse && k == 3) begin
                m_idelay_out = value;
            end else begin
                m_idelay_out[`IDELAY_LOAD_BIT] = 1'b0;
            end
            check_idelay($sformatf("%s cycle %0d", name, k), m_idelay_out, idelay);
        end
        read_check({name, " readback"}, `ADDR_IDELAY, model_read(`ADDR_IDELAY), 1'b0);
    endtask

    task automatic idelay_checks();
        logic [31:0] rnd;
        rnd = $random(seed);
        idelay_write("idelay first load", {1'b1, rnd[1:0]});
        idelay_write("idelay load held", {1'b1, rnd[3:2]});
        idelay_write("idelay load cleared", {1'b0, rnd[5:4]});
        idelay_write("idelay second load", {1'b1, rnd[7:6]});
    endtask

    initial begin
        seed        = 32'h7ee;
        clk         = 1'b0;
        rst         = 1'b1;
        paddr       = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        pwdata      = '0;
        user_status = '{default: '0};
        reset_model();
        build_addr_list();
        repeat (RST_CYCLES) @(negedge clk);
        rst = 1'b0;

        //////////////////////////////
        // State after reset
        @(negedge clk);
        check_flag("pready after reset", 1'b0, pready);
        check_flag("pslverr after reset", 1'b0, pslverr);
        check_data("prdata after reset", '0, prdata);
        check_outputs("reset outputs", '0);
        sweep_readback("reset readback");

        status_checks();
        random_xfers();
        error_checks();
        idelay_checks();

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+source
+incdir+tests
source/adq_regs_pkg.sv
source/apb_reg_port.sv
source/board_reg_bank.sv
source/adc_cal_regs.sv
source/idelay_strobe.sv
source/adq_regs_top.sv
tests/adq_regs_tb.sv

// File: build.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -Wno-fatal -f all.f --top-module adq_regs_tb -o adq_regs_sim
./obj_dir/adq_regs_sim
